// File: build.f
rtl/approx_div_pkg.sv
rtl/borrow_sub_cell.sv
rtl/array_divider.sv
rtl/div_error_monitor.sv
rtl/approx_div_top.sv
verification/approx_div_asserts.sv
verification/approx_div_tb.sv

// File: rtl/approx_div_pkg.sv
`default_nettype none

package approx_div_pkg;

  // operand widths.
  localparam int DIVIDEND_W = 16;
  localparam int DIVISOR_W  = 8;

  // one array row per quotient bit.
  localparam int NUM_ROWS = DIVIDEND_W - DIVISOR_W;

  // Rows 0 .. APPROX_ROWS-1 of the approximate divider use the simplified cell.
  localparam int APPROX_ROWS = 4;

  // cell mode selectors for borrow_sub_cell.
  localparam int CELL_EXACT  = 0;
  localparam int CELL_APPROX = 1;

  // statistics counters.
  localparam int ERR_SUM_W = 32;
  localparam logic [ERR_SUM_W-1:0] ERR_SUM_MAX = {ERR_SUM_W{1'b1}};

endpackage

`default_nettype wire

// File: rtl/approx_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module approx_div_top import approx_div_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  input  logic [DIVIDEND_W-1:0] dividend,
  input  logic [DIVISOR_W-1:0]  divisor,
  input  logic                  stats_clr,
  output logic                  out_valid,
  output logic [DIVISOR_W-1:0]  q_exact,
  output logic [DIVISOR_W-1:0]  r_exact,
  output logic [DIVISOR_W-1:0]  q_approx,
  output logic [DIVISOR_W-1:0]  r_approx,
  output logic                  div_ovf,
  output logic [ERR_SUM_W-1:0]  op_count,
  output logic [ERR_SUM_W-1:0]  mismatch_count,
  output logic [ERR_SUM_W-1:0]  err_sum
);

  logic                  op_valid;
  logic [DIVIDEND_W-1:0] op_dividend;
  logic [DIVISOR_W-1:0]  op_divisor;
  logic                  ovf;
  logic                  sample;
  logic [DIVISOR_W-1:0]  q_ex_c;
  logic [DIVISOR_W-1:0]  r_ex_c;
  logic [DIVISOR_W-1:0]  q_ap_c;
  logic [DIVISOR_W-1:0]  r_ap_c;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid <= 1'b0;
    end else begin
      op_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      op_dividend <= dividend;
      op_divisor  <= divisor;
    end
  end

  // quotient needs more than 8 bits, divisor zero lands here too.
  assign ovf = (op_dividend[DIVIDEND_W-1 -: DIVISOR_W] >= op_divisor);

  assign sample = op_valid & ~ovf;

  array_divider #(
    .APPROX_ROWS (0)
  ) exact_div_inst (
    .n (op_dividend),
    .d (op_divisor),
    .q (q_ex_c),
    .r (r_ex_c)
  );

  array_divider #(
    .APPROX_ROWS (APPROX_ROWS)
  ) approx_div_inst (
    .n (op_dividend),
    .d (op_divisor),
    .q (q_ap_c),
    .r (r_ap_c)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      div_ovf   <= 1'b0;
      q_exact   <= '0;
      r_exact   <= '0;
      q_approx  <= '0;
      r_approx  <= '0;
    end else begin
      out_valid <= op_valid;
      if (op_valid) begin                           // hold the last result otherwise.
        div_ovf  <= ovf;
        q_exact  <= q_ex_c;
        r_exact  <= r_ex_c;
        q_approx <= q_ap_c;
        r_approx <= r_ap_c;
      end
    end
  end

  div_error_monitor monitor_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .stats_clr      (stats_clr),
    .sample         (sample),
    .q_exact        (q_ex_c),
    .q_approx       (q_ap_c),
    .op_count       (op_count),
    .mismatch_count (mismatch_count),
    .err_sum        (err_sum)
  );

endmodule

`default_nettype wire

// File: rtl/array_divider.sv
`timescale 1ns/1ps
`default_nettype none

module array_divider import approx_div_pkg::*; #(
  parameter int APPROX_ROWS = approx_div_pkg::APPROX_ROWS
) (
  input  logic [DIVIDEND_W-1:0] n,
  input  logic [DIVISOR_W-1:0]  d,
  output logic [DIVISOR_W-1:0]  q,
  output logic [DIVISOR_W-1:0]  r
);

  // Row k produces quotient bit k. The top row works on the dividend's
  // upper bits, every lower row on the restored remainder of the row above
  // shifted left by one with the next dividend bit brought in at column 0.

  logic [DIVISOR_W-1:0] above [NUM_ROWS];  // partial remainder entering each row.
  logic [DIVISOR_W-1:0] x_row [NUM_ROWS];  // minuend bits of each row.
  logic [DIVISOR_W-1:0] b_row [NUM_ROWS];  // borrow chain of each row.
  logic [DIVISOR_W-1:0] r_row [NUM_ROWS];  // restored remainder of each row.

  genvar k;
  genvar j;

  generate
    for (k = 0; k < NUM_ROWS; k++) begin : g_row
      localparam int CELL_MODE = (k < APPROX_ROWS) ? CELL_APPROX : CELL_EXACT;

      if (k == NUM_ROWS - 1) begin : g_top
        assign above[k] = n[DIVIDEND_W-1 -: DIVISOR_W];  // dividend bits 15..8.
      end else begin : g_inner
        assign above[k] = r_row[k+1];
      end

      assign x_row[k] = {above[k][DIVISOR_W-2:0], n[k]};

      // The msb that falls off the shift means the subtraction cannot fail.
      assign q[k] = above[k][DIVISOR_W-1] | ~b_row[k][DIVISOR_W-1];

      for (j = 0; j < DIVISOR_W; j++) begin : g_col
        logic bin_in;

        if (j == 0) begin : g_lsb
          assign bin_in = 1'b0;                        // no borrow into column 0.
        end else begin : g_chain
          assign bin_in = b_row[k][j-1];
        end

        borrow_sub_cell #(
          .APPROX (CELL_MODE)
        ) cell_inst (
          .x     (x_row[k][j]),
          .y     (d[j]),
          .bin   (bin_in),
          .qs    (q[k]),
          .r_sub (r_row[k][j]),
          .bout  (b_row[k][j])
        );
      end
    end
  endgenerate

  assign r = r_row[0];                                 // final remainder from row 0.

endmodule

`default_nettype wire

// File: rtl/borrow_sub_cell.sv
`timescale 1ns/1ps
`default_nettype none

module borrow_sub_cell import approx_div_pkg::*; #(
  parameter int APPROX = CELL_EXACT
) (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  generate
    if (APPROX == CELL_APPROX) begin : g_approx
      // simplified cell, the borrow in is ignored.
      assign bout = x & y;
      assign diff = y;
    end else begin : g_exact
      assign diff = x ^ y ^ bin;                       // full subtractor difference.
      assign bout = (~x & y) | (~(x ^ y) & bin);       // borrow out.
    end
  endgenerate

  // Restore path: when the row's trial subtraction borrows out, qs is low
  // and the minuend bit passes through unchanged.
  assign r_sub = qs ? diff : x;

endmodule

`default_nettype wire

// File: rtl/div_error_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module div_error_monitor import approx_div_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stats_clr,
  input  logic                 sample,
  input  logic [DIVISOR_W-1:0] q_exact,
  input  logic [DIVISOR_W-1:0] q_approx,
  output logic [ERR_SUM_W-1:0] op_count,
  output logic [ERR_SUM_W-1:0] mismatch_count,
  output logic [ERR_SUM_W-1:0] err_sum
);

  logic                 q_differ;
  logic [DIVISOR_W-1:0] abs_err;
  logic [ERR_SUM_W:0]   err_sum_ext;  // one extra bit to catch the carry.

  assign q_differ = (q_exact != q_approx);

  assign abs_err = (q_exact > q_approx) ? (q_exact - q_approx) :
                                          (q_approx - q_exact);

  assign err_sum_ext = {1'b0, err_sum} +
                       {{(ERR_SUM_W + 1 - DIVISOR_W){1'b0}}, abs_err};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_count       <= '0;
      mismatch_count <= '0;
      err_sum        <= '0;
    end else if (stats_clr) begin                    // clear wins over a sample.
      op_count       <= '0;
      mismatch_count <= '0;
      err_sum        <= '0;
    end else if (sample) begin
      if (op_count != ERR_SUM_MAX) begin
        op_count <= op_count + 1'b1;
      end
      if (q_differ && (mismatch_count != ERR_SUM_MAX)) begin
        mismatch_count <= mismatch_count + 1'b1;
      end
      if (err_sum_ext[ERR_SUM_W]) begin
        err_sum <= ERR_SUM_MAX;                      // saturate instead of wrap.
      end else begin
        err_sum <= err_sum_ext[ERR_SUM_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=approx_div_sim
LOG_FILE=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module approx_div_tb \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG_FILE"; then
  exit 1
fi

if ! grep -q "TEST PASSED" "$LOG_FILE"; then
  echo "no verdict found in $LOG_FILE"
  exit 1
fi

exit 0

// File: verification/approx_div_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module approx_div_asserts import approx_div_pkg::*; (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  in_valid,
  input logic [DIVIDEND_W-1:0] dividend,
  input logic [DIVISOR_W-1:0]  divisor,
  input logic                  stats_clr,
  input logic                  out_valid,
  input logic [DIVISOR_W-1:0]  q_exact,
  input logic [DIVISOR_W-1:0]  r_exact,
  input logic [DIVISOR_W-1:0]  q_approx,
  input logic [DIVISOR_W-1:0]  r_approx,
  input logic                  div_ovf,
  input logic [ERR_SUM_W-1:0]  op_count,
  input logic [ERR_SUM_W-1:0]  mismatch_count,
  input logic [ERR_SUM_W-1:0]  err_sum
);

  int error_count = 0;  // read by the testbench.

  logic                   v1;
  logic                   v2;
  logic [DIVIDEND_W-1:0]  n1;
  logic [DIVIDEND_W-1:0]  n2;
  logic [DIVISOR_W-1:0]   d1;
  logic [DIVISOR_W-1:0]   d2;
  logic                   ovf1;
  logic                   ovf2;
  logic [DIVISOR_W-1:0]   q1;
  logic [2*DIVISOR_W-1:0] rule1;
  logic [DIVISOR_W-1:0]   qa1;
  logic [DIVISOR_W-1:0]   abs1;
  logic [DIVISOR_W-1:0]   exp_q2;
  logic [DIVISOR_W-1:0]   exp_r2;
  logic [DIVISOR_W-1:0]   exp_qa2;
  logic [DIVISOR_W-1:0]   exp_ra2;
  logic [ERR_SUM_W-1:0]   m_ops;
  logic [ERR_SUM_W-1:0]   m_mis;
  logic [ERR_SUM_W-1:0]   m_err;

  // bit-level walk of the array, row by row from quotient bit 7 down.
  function automatic logic [2*DIVISOR_W-1:0] approx_rule(input logic [DIVIDEND_W-1:0] n,
                                                          input logic [DIVISOR_W-1:0]  d);
    logic [DIVISOR_W-1:0] rem;
    logic [DIVISOR_W-1:0] x;
    logic [DIVISOR_W-1:0] diff;
    logic [DIVISOR_W-1:0] q;
    logic                 b;
    logic                 qk;
    rem = n[DIVIDEND_W-1 -: DIVISOR_W];
    q = '0;
    for (int k = NUM_ROWS - 1; k >= 0; k--) begin
      x = {rem[DIVISOR_W-2:0], n[k]};
      b = 1'b0;
      for (int j = 0; j < DIVISOR_W; j++) begin
        if (k < APPROX_ROWS) begin
          diff[j] = d[j];                              // simplified cell.
          b = x[j] & d[j];
        end else begin
          diff[j] = x[j] ^ d[j] ^ b;
          b = (~x[j] & d[j]) | (~(x[j] ^ d[j]) & b);
        end
      end
      qk = rem[DIVISOR_W-1] | ~b;
      q[k] = qk;
      rem = qk ? diff : x;
    end
    return {q, rem};
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= in_valid;
      v2 <= v1;
    end
  end

  always_ff @(posedge clk) begin
    n1 <= dividend;
    d1 <= divisor;
    n2 <= n1;
    d2 <= d1;
  end

  assign ovf1 = (n1[DIVIDEND_W-1 -: DIVISOR_W] >= d1);
  assign ovf2 = (n2[DIVIDEND_W-1 -: DIVISOR_W] >= d2);

  always_comb begin
    q1 = '0;
    exp_q2 = '0;
    exp_r2 = '0;
    if (!ovf1) begin
      q1 = DIVISOR_W'(n1 / DIVIDEND_W'(d1));
    end
    if (!ovf2) begin
      exp_q2 = DIVISOR_W'(n2 / DIVIDEND_W'(d2));
      exp_r2 = DIVISOR_W'(n2 % DIVIDEND_W'(d2));
    end
  end

  assign rule1 = approx_rule(n1, d1);
  assign qa1 = rule1[2*DIVISOR_W-1 -: DIVISOR_W];
  assign abs1 = (q1 > qa1) ? (q1 - qa1) : (qa1 - q1);
  assign {exp_qa2, exp_ra2} = approx_rule(n2, d2);

  // running totals over the legal ops.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_ops <= '0;
      m_mis <= '0;
      m_err <= '0;
    end else if (stats_clr) begin
      m_ops <= '0;
      m_mis <= '0;
      m_err <= '0;
    end else if (v1 && !ovf1) begin
      m_ops <= m_ops + 1;
      if (q1 != qa1) begin
        m_mis <= m_mis + 1;
      end
      m_err <= m_err + ERR_SUM_W'(abs1);
    end
  end

  reset_a: assert property (@(posedge clk)
    !arst_n |-> (!out_valid && op_count == '0 && mismatch_count == '0 && err_sum == '0))
    else begin
      error_count = error_count + 1;
      $error("[ERROR] reset: expected out_valid 0 counters 0, actual out_valid %0b ops %0d",
             $sampled(out_valid), $sampled(op_count));
    end

  latency_a: assert property (@(posedge clk) disable iff (!arst_n) out_valid == v2)
    else begin
      error_count = error_count + 1;
      $error("[ERROR] latency: expected out_valid %0b, actual %0b",
             $sampled(v2), $sampled(out_valid));
    end

  overflow_a: assert property (@(posedge clk) disable iff (!arst_n) v2 |-> div_ovf == ovf2)
    else begin
      error_count = error_count + 1;
      $error("[ERROR] overflow: expected div_ovf %0b, actual %0b",
             $sampled(ovf2), $sampled(div_ovf));
    end

  exact_a: assert property (@(posedge clk) disable iff (!arst_n)
    (v2 && !ovf2) |-> (q_exact == exp_q2 && r_exact == exp_r2))
    else begin
      error_count = error_count + 1;
      $error("[ERROR] exact_path: expected q %0d r %0d, actual q %0d r %0d",
             $sampled(exp_q2), $sampled(exp_r2), $sampled(q_exact), $sampled(r_exact));
    end

  approx_a: assert property (@(posedge clk) disable iff (!arst_n)
    (v2 && !ovf2) |-> (q_approx == exp_qa2 && r_approx == exp_ra2))
    else begin
      error_count = error_count + 1;
      $error("[ERROR] approx_path: expected q %0d r %0d, actual q %0d r %0d",
             $sampled(exp_qa2), $sampled(exp_ra2), $sampled(q_approx), $sampled(r_approx));
    end

  monitor_a: assert property (@(posedge clk) disable iff (!arst_n)
    (op_count == m_ops && mismatch_count == m_mis && err_sum == m_err))
    else begin
      error_count = error_count + 1;
      $error("[ERROR] monitor: expected %0d/%0d/%0d, actual %0d/%0d/%0d",
             $sampled(m_ops), $sampled(m_mis), $sampled(m_err),
             $sampled(op_count), $sampled(mismatch_count), $sampled(err_sum));
    end

endmodule

`default_nettype wire

// File: verification/approx_div_tb.sv
`timescale 1ns/1ps
`default_nettype none

module approx_div_tb import approx_div_pkg::*; ();

  localparam int CLK_HALF       = 20;
  localparam int RESET_CYCLES   = 8;
  localparam int RANDOM_OPS     = 300;
  localparam int TEST_CYCLES    = 10 + 60 + 30 + 330 + 90 + 80;  // per-test lengths.
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                  clk;
  logic                  arst_n;
  logic                  in_valid;
  logic [DIVIDEND_W-1:0] dividend;
  logic [DIVISOR_W-1:0]  divisor;
  logic                  stats_clr;
  logic                  out_valid;
  logic [DIVISOR_W-1:0]  q_exact;
  logic [DIVISOR_W-1:0]  r_exact;
  logic [DIVISOR_W-1:0]  q_approx;
  logic [DIVISOR_W-1:0]  r_approx;
  logic                  div_ovf;
  logic [ERR_SUM_W-1:0]  op_count;
  logic [ERR_SUM_W-1:0]  mismatch_count;
  logic [ERR_SUM_W-1:0]  err_sum;

  int cycle_count    = 0;
  int issued_count   = 0;
  int received_count = 0;
  int tests_run      = 0;
  int tests_failed   = 0;
  int mark;

  approx_div_top approx_div_top_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .dividend       (dividend),
    .divisor        (divisor),
    .stats_clr      (stats_clr),
    .out_valid      (out_valid),
    .q_exact        (q_exact),
    .r_exact        (r_exact),
    .q_approx       (q_approx),
    .r_approx       (r_approx),
    .div_ovf        (div_ovf),
    .op_count       (op_count),
    .mismatch_count (mismatch_count),
    .err_sum        (err_sum)
  );

  bind approx_div_top approx_div_asserts asserts_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .dividend       (dividend),
    .divisor        (divisor),
    .stats_clr      (stats_clr),
    .out_valid      (out_valid),
    .q_exact        (q_exact),
    .r_exact        (r_exact),
    .q_approx       (q_approx),
    .r_approx       (r_approx),
    .div_ovf        (div_ovf),
    .op_count       (op_count),
    .mismatch_count (mismatch_count),
    .err_sum        (err_sum)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      received_count <= received_count + 1;
    end
  end

  function automatic int current_errors();
    return approx_div_top_inst.asserts_inst.error_count;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic issue_op(input logic [DIVIDEND_W-1:0] n, input logic [DIVISOR_W-1:0] d);
    @(posedge clk);
    in_valid <= 1'b1;
    dividend <= n;
    divisor  <= d;
    issued_count++;
  endtask

  task automatic stop_input();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // upper byte below the divisor, so the quotient fits in 8 bits.
  task automatic issue_legal();
    logic [DIVISOR_W-1:0] d;
    logic [DIVISOR_W-1:0] hi;
    logic [DIVISOR_W-1:0] lo;
    d  = DIVISOR_W'($urandom_range(255, 1));
    hi = DIVISOR_W'($urandom_range(d - 8'd1, 0));
    lo = DIVISOR_W'($urandom);
    issue_op({hi, lo}, d);
  endtask

  task automatic issue_overflow();
    logic [DIVISOR_W-1:0] d;
    logic [DIVISOR_W-1:0] hi;
    d  = DIVISOR_W'($urandom_range(255, 0));
    hi = DIVISOR_W'($urandom_range(255, d));
    issue_op({hi, DIVISOR_W'($urandom)}, d);
  endtask

  task automatic drain_results();
    do begin
      @(posedge clk);
    end while (received_count != issued_count);
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    stats_clr <= 1'b1;
    @(posedge clk);
    stats_clr <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    int delta;
    @(negedge clk);                                    // checks of the last edge are done.
    delta = current_errors() - errors_before;
    tests_run++;
    if (delta != 0) begin
      tests_failed++;
    end
    $display("test %-12s %s (%0d assertion errors)", name, (delta == 0) ? "ok" : "failed", delta);
  endtask

  initial begin
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    dividend  = '0;
    divisor   = '0;
    stats_clr = 1'b0;
    void'($urandom(64436));

    mark = current_errors();
    wait_cycles(RESET_CYCLES);
    arst_n <= 1'b1;
    wait_cycles(2);
    report_test("reset", mark);

    mark = current_errors();
    for (int i = 0; i < 16; i++) begin
      issue_legal();                                   // back-to-back burst.
    end
    stop_input();
    for (int gap = 1; gap <= 3; gap++) begin
      issue_legal();
      stop_input();
      wait_cycles(gap);
    end
    drain_results();
    report_test("latency", mark);

    mark = current_errors();
    issue_op(16'h00FF, 8'h01);
    issue_op(16'h0000, 8'h01);
    issue_op(16'hFEFF, 8'hFF);
    issue_op(16'hFE00, 8'hFF);
    issue_op(16'h0000, 8'hFF);
    issue_op(16'h0000, 8'h7B);
    issue_op(16'h7FFF, 8'h80);
    issue_op(16'h0FA5, 8'h10);
    issue_op(16'h0201, 8'h03);
    stop_input();
    drain_results();
    report_test("exact_edges", mark);

    mark = current_errors();
    for (int i = 0; i < RANDOM_OPS; i++) begin
      issue_legal();
    end
    stop_input();
    drain_results();
    report_test("random_legal", mark);

    mark = current_errors();
    issue_op(16'h1234, 8'h00);
    issue_op(16'h0000, 8'h00);
    issue_op(16'h5000, 8'h50);
    issue_op(16'hFF00, 8'h01);
    issue_op(16'h8000, 8'h7F);
    for (int i = 0; i < 40; i++) begin
      if (i % 2 == 1) begin
        issue_overflow();
      end else begin
        issue_legal();
      end
    end
    stop_input();
    drain_results();
    report_test("overflow", mark);

    mark = current_errors();
    pulse_clear();
    wait_cycles(2);
    for (int i = 0; i < 20; i++) begin
      issue_legal();
    end
    stop_input();
    drain_results();
    issue_op(16'h1234, 8'h40);
    @(posedge clk);
    in_valid  <= 1'b0;
    stats_clr <= 1'b1;                                 // lands on the sample edge.
    @(posedge clk);
    stats_clr <= 1'b0;
    drain_results();
    for (int i = 0; i < 10; i++) begin
      issue_legal();
    end
    stop_input();
    drain_results();
    pulse_clear();
    wait_cycles(2);
    report_test("monitor", mark);

    $display("summary: %0d tests, %0d failed, %0d assertion errors",
             tests_run, tests_failed, current_errors());
    if (tests_failed == 0 && current_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
